// ==== Makefile ====
# Verilator build and run for the RV32I pipeline testbench

VERILATOR := verilator
VFLAGS    := --binary --timescale 1ns/1ps -j 0
TOP       := rv_core_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
PASS_MSG  := sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it, check for the pass line"
	@echo "  clean  remove the Verilator build directory"

# Status is taken from the search for the pass line
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== source/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
  parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  output logic [rv_core_pkg::XLEN-1:0] imem_addr_o,
  input  logic [31:0]                  imem_rdata_i,
  output logic                         dmem_re_o,
  output logic                         dmem_we_o,
  output logic [rv_core_pkg::XLEN-1:0] dmem_addr_o,
  output logic [rv_core_pkg::XLEN-1:0] dmem_wdata_o,
  input  logic [rv_core_pkg::XLEN-1:0] dmem_rdata_i,
  output logic                         retire_valid_o,
  output rv_core_pkg::reg_addr_t       retire_rd_o,
  output logic [rv_core_pkg::XLEN-1:0] retire_data_o
);
  import rv_core_pkg::*;

  // Hazard control
  logic            stall;
  logic            flush_id;
  logic            flush_ex;
  fwd_sel_e        fwd_a;
  fwd_sel_e        fwd_b;

  // Fetch and IF/ID
  logic [XLEN-1:0] if_pc;
  logic [31:0]     if_id_instr;
  logic [XLEN-1:0] if_id_pc;

  // Decode
  reg_addr_t       id_rs1;
  reg_addr_t       id_rs2;
  reg_addr_t       id_rd;
  logic [XLEN-1:0] id_imm;
  alu_op_e         id_alu_op;
  src_b_e          id_src_b;
  logic            id_reg_write;
  logic            id_mem_read;
  logic            id_mem_write;
  logic            id_branch;
  logic            id_branch_ne;
  logic [XLEN-1:0] id_rdata1;
  logic [XLEN-1:0] id_rdata2;

  // ID/EX
  logic            id_ex_reg_write;
  logic            id_ex_mem_read;
  logic            id_ex_mem_write;
  logic            id_ex_branch;
  logic            id_ex_branch_ne;
  logic [XLEN-1:0] id_ex_pc;
  logic [XLEN-1:0] id_ex_rdata1;
  logic [XLEN-1:0] id_ex_rdata2;
  logic [XLEN-1:0] id_ex_imm;
  reg_addr_t       id_ex_rs1;
  reg_addr_t       id_ex_rs2;
  reg_addr_t       id_ex_rd;
  alu_op_e         id_ex_alu_op;
  src_b_e          id_ex_src_b;

  // Execute
  logic [XLEN-1:0] ex_alu_result;
  logic [XLEN-1:0] ex_store_data;
  logic            ex_branch_taken;
  logic [XLEN-1:0] ex_branch_target;

  // EX/MEM and memory stage
  logic            ex_mem_reg_write;
  logic            ex_mem_mem_read;
  logic            ex_mem_mem_write;
  reg_addr_t       ex_mem_rd;
  logic [XLEN-1:0] ex_mem_alu_result;
  logic [XLEN-1:0] ex_mem_store_data;
  logic [XLEN-1:0] mem_result;

  // MEM/WB
  logic            mem_wb_reg_write;
  reg_addr_t       mem_wb_rd;
  logic [XLEN-1:0] mem_wb_result;

  // ======================================
  // Fetch
  // ======================================

  rv_fetch #(
    .RESET_PC(RESET_PC)
  ) u_rv_fetch (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .stall_i        (stall),
    .branch_taken_i (ex_branch_taken),
    .branch_target_i(ex_branch_target),
    .pc_o           (if_pc),
    .pc_plus4_o     ()
  );

  assign imem_addr_o = if_pc;

  // Flush wins over the load-use hold
  always_ff @(posedge clk_i) begin
    if (!rst_ni || flush_id) begin
      if_id_instr <= NOP_INSTR;
    end else if (!stall) begin
      if_id_instr <= imem_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      if_id_pc <= if_pc;
    end
  end

  // ======================================
  // Decode
  // ======================================

  rv_decode u_rv_decode (
    .instr_i    (if_id_instr),
    .rs1_o      (id_rs1),
    .rs2_o      (id_rs2),
    .rd_o       (id_rd),
    .imm_o      (id_imm),
    .alu_op_o   (id_alu_op),
    .src_b_o    (id_src_b),
    .reg_write_o(id_reg_write),
    .mem_read_o (id_mem_read),
    .mem_write_o(id_mem_write),
    .branch_o   (id_branch),
    .branch_ne_o(id_branch_ne)
  );

  // Written from writeback, read in decode
  rv_regfile u_rv_regfile (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .rs1_i   (id_rs1),
    .rs2_i   (id_rs2),
    .rd_i    (mem_wb_rd),
    .we_i    (mem_wb_reg_write),
    .wdata_i (mem_wb_result),
    .rdata1_o(id_rdata1),
    .rdata2_o(id_rdata2)
  );

  // Control bits of ID/EX
  // Cleared for a load-use bubble or a taken branch
  always_ff @(posedge clk_i) begin
    if (!rst_ni || flush_ex) begin
      id_ex_reg_write <= 1'b0;
      id_ex_mem_read  <= 1'b0;
      id_ex_mem_write <= 1'b0;
      id_ex_branch    <= 1'b0;
      id_ex_branch_ne <= 1'b0;
    end else begin
      id_ex_reg_write <= id_reg_write;
      id_ex_mem_read  <= id_mem_read;
      id_ex_mem_write <= id_mem_write;
      id_ex_branch    <= id_branch;
      id_ex_branch_ne <= id_branch_ne;
    end
  end

  // Operands and fields of ID/EX
  always_ff @(posedge clk_i) begin
    id_ex_pc     <= if_id_pc;
    id_ex_rdata1 <= id_rdata1;
    id_ex_rdata2 <= id_rdata2;
    id_ex_imm    <= id_imm;
    id_ex_rs1    <= id_rs1;
    id_ex_rs2    <= id_rs2;
    id_ex_rd     <= id_rd;
    id_ex_alu_op <= id_alu_op;
    id_ex_src_b  <= id_src_b;
  end

  // ======================================
  // Execute
  // ======================================

  rv_execute u_rv_execute (
    .pc_i           (id_ex_pc),
    .rdata1_i       (id_ex_rdata1),
    .rdata2_i       (id_ex_rdata2),
    .imm_i          (id_ex_imm),
    .mem_result_i   (mem_result),
    .wb_result_i    (mem_wb_result),
    .fwd_a_i        (fwd_a),
    .fwd_b_i        (fwd_b),
    .alu_op_i       (id_ex_alu_op),
    .src_b_i        (id_ex_src_b),
    .branch_i       (id_ex_branch),
    .branch_ne_i    (id_ex_branch_ne),
    .alu_result_o   (ex_alu_result),
    .store_data_o   (ex_store_data),
    .branch_taken_o (ex_branch_taken),
    .branch_target_o(ex_branch_target)
  );

  rv_hazard_unit u_rv_hazard_unit (
    .id_rs1_i       (id_rs1),
    .id_rs2_i       (id_rs2),
    .ex_rs1_i       (id_ex_rs1),
    .ex_rs2_i       (id_ex_rs2),
    .ex_rd_i        (id_ex_rd),
    .ex_mem_read_i  (id_ex_mem_read),
    .mem_rd_i       (ex_mem_rd),
    .mem_reg_write_i(ex_mem_reg_write),
    .wb_rd_i        (mem_wb_rd),
    .wb_reg_write_i (mem_wb_reg_write),
    .branch_taken_i (ex_branch_taken),
    .fwd_a_o        (fwd_a),
    .fwd_b_o        (fwd_b),
    .stall_o        (stall),
    .flush_id_o     (flush_id),
    .flush_ex_o     (flush_ex)
  );

  // A branch never flushes itself, so EX/MEM only resets
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ex_mem_reg_write <= 1'b0;
      ex_mem_mem_read  <= 1'b0;
      ex_mem_mem_write <= 1'b0;
    end else begin
      ex_mem_reg_write <= id_ex_reg_write;
      ex_mem_mem_read  <= id_ex_mem_read;
      ex_mem_mem_write <= id_ex_mem_write;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_mem_rd         <= id_ex_rd;
    ex_mem_alu_result <= ex_alu_result;
    ex_mem_store_data <= ex_store_data;
  end

  // ======================================
  // Memory and writeback
  // ======================================

  // Data memory answers in the same cycle
  assign dmem_re_o    = ex_mem_mem_read;
  assign dmem_we_o    = ex_mem_mem_write;
  assign dmem_addr_o  = ex_mem_alu_result;
  assign dmem_wdata_o = ex_mem_store_data;

  // Load data or ALU result, also the memory-stage forward value
  assign mem_result = ex_mem_mem_read ? dmem_rdata_i : ex_mem_alu_result;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mem_wb_reg_write <= 1'b0;
    end else begin
      mem_wb_reg_write <= ex_mem_reg_write;
    end
  end

  always_ff @(posedge clk_i) begin
    mem_wb_rd     <= ex_mem_rd;
    mem_wb_result <= mem_result;
  end

  // Retire only writes that change state
  assign retire_valid_o = mem_wb_reg_write && (mem_wb_rd != '0);
  assign retire_rd_o    = mem_wb_rd;
  assign retire_data_o  = mem_wb_result;

endmodule

// ==== source/rv_core_pkg.sv ====
package rv_core_pkg;

  // ======================================
  // Widths
  // ======================================

  // Data and address width
  localparam int unsigned XLEN = 32;

  // Register index
  typedef logic [4:0] reg_addr_t;

  // ======================================
  // Control encodings
  // ======================================

  // ALU operation
  // PASS_B hands the immediate through for LUI
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // Second ALU operand
  typedef enum logic {
    SRC_B_REG,
    SRC_B_IMM
  } src_b_e;

  // Operand source in execute
  typedef enum logic [1:0] {
    FWD_RF,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

  // ======================================
  // RV32I opcodes
  // ======================================

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // ADDI x0, x0, 0
  localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

// ==== source/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
  input  logic [31:0]                  instr_i,
  output rv_core_pkg::reg_addr_t       rs1_o,
  output rv_core_pkg::reg_addr_t       rs2_o,
  output rv_core_pkg::reg_addr_t       rd_o,
  output logic [rv_core_pkg::XLEN-1:0] imm_o,
  output rv_core_pkg::alu_op_e         alu_op_o,
  output rv_core_pkg::src_b_e          src_b_o,
  output logic                         reg_write_o,
  output logic                         mem_read_o,
  output logic                         mem_write_o,
  output logic                         branch_o,
  output logic                         branch_ne_o
);
  import rv_core_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            funct3_ok;
  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_s_type;
  logic [XLEN-1:0] imm_b_type;
  logic [XLEN-1:0] imm_u_type;

  // Funct3 map shared by the register and immediate forms
  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic sub);
    case (f3)
      3'b010:  return ALU_SLT;
      3'b100:  return ALU_XOR;
      3'b110:  return ALU_OR;
      3'b111:  return ALU_AND;
      default: return sub ? ALU_SUB : ALU_ADD;
    endcase
  endfunction

  assign opcode    = instr_i[6:0];
  assign funct3    = instr_i[14:12];
  assign funct3_ok = funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};

  // Immediate formats, all sign extended from bit 31
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  always_comb begin
    // Defaults describe a no-op
    // Unused register fields stay zero so they never match a hazard
    rs1_o       = '0;
    rs2_o       = '0;
    rd_o        = '0;
    imm_o       = '0;
    alu_op_o    = ALU_ADD;
    src_b_o     = SRC_B_REG;
    reg_write_o = 1'b0;
    mem_read_o  = 1'b0;
    mem_write_o = 1'b0;
    branch_o    = 1'b0;
    branch_ne_o = 1'b0;

    case (opcode)
      OPC_OP: begin
        rs1_o       = instr_i[19:15];
        rs2_o       = instr_i[24:20];
        rd_o        = instr_i[11:7];
        alu_op_o    = alu_from_funct3(funct3, instr_i[30]);
        reg_write_o = funct3_ok;
      end
      OPC_OP_IMM: begin
        rs1_o       = instr_i[19:15];
        rd_o        = instr_i[11:7];
        imm_o       = imm_i_type;
        src_b_o     = SRC_B_IMM;
        alu_op_o    = alu_from_funct3(funct3, 1'b0);
        reg_write_o = funct3_ok;
      end
      OPC_LUI: begin
        rd_o        = instr_i[11:7];
        imm_o       = imm_u_type;
        src_b_o     = SRC_B_IMM;
        alu_op_o    = ALU_PASS_B;
        reg_write_o = 1'b1;
      end
      OPC_LOAD: begin
        // Effective address is rs1 plus offset
        rs1_o       = instr_i[19:15];
        rd_o        = instr_i[11:7];
        imm_o       = imm_i_type;
        src_b_o     = SRC_B_IMM;
        reg_write_o = 1'b1;
        mem_read_o  = 1'b1;
      end
      OPC_STORE: begin
        rs1_o       = instr_i[19:15];
        rs2_o       = instr_i[24:20];
        imm_o       = imm_s_type;
        src_b_o     = SRC_B_IMM;
        mem_write_o = 1'b1;
      end
      OPC_BRANCH: begin
        // Only BEQ and BNE
        rs1_o       = instr_i[19:15];
        rs2_o       = instr_i[24:20];
        imm_o       = imm_b_type;
        branch_o    = (funct3[2:1] == 2'b00);
        branch_ne_o = funct3[0];
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== source/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
  input  logic [rv_core_pkg::XLEN-1:0] pc_i,
  input  logic [rv_core_pkg::XLEN-1:0] rdata1_i,
  input  logic [rv_core_pkg::XLEN-1:0] rdata2_i,
  input  logic [rv_core_pkg::XLEN-1:0] imm_i,
  input  logic [rv_core_pkg::XLEN-1:0] mem_result_i,
  input  logic [rv_core_pkg::XLEN-1:0] wb_result_i,
  input  rv_core_pkg::fwd_sel_e        fwd_a_i,
  input  rv_core_pkg::fwd_sel_e        fwd_b_i,
  input  rv_core_pkg::alu_op_e         alu_op_i,
  input  rv_core_pkg::src_b_e          src_b_i,
  input  logic                         branch_i,
  input  logic                         branch_ne_i,
  output logic [rv_core_pkg::XLEN-1:0] alu_result_o,
  output logic [rv_core_pkg::XLEN-1:0] store_data_o,
  output logic                         branch_taken_o,
  output logic [rv_core_pkg::XLEN-1:0] branch_target_o
);
  import rv_core_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b_reg;
  logic [XLEN-1:0] op_b;
  logic            less_than;
  logic            equal;

  // Operand source picked by the hazard unit
  function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e        sel,
                                               input logic [XLEN-1:0] rf_val,
                                               input logic [XLEN-1:0] mem_val,
                                               input logic [XLEN-1:0] wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return rf_val;
    endcase
  endfunction

  // ======================================
  // Operands
  // ======================================

  assign op_a     = fwd_mux(fwd_a_i, rdata1_i, mem_result_i, wb_result_i);
  assign op_b_reg = fwd_mux(fwd_b_i, rdata2_i, mem_result_i, wb_result_i);
  assign op_b     = (src_b_i == SRC_B_IMM) ? imm_i : op_b_reg;

  // Store data is always the forwarded rs2
  assign store_data_o = op_b_reg;

  // ======================================
  // ALU
  // ======================================

  // SLT is signed
  assign less_than = $signed(op_a) < $signed(op_b);

  always_comb begin
    case (alu_op_i)
      ALU_ADD:    alu_result_o = op_a + op_b;
      ALU_SUB:    alu_result_o = op_a - op_b;
      ALU_AND:    alu_result_o = op_a & op_b;
      ALU_OR:     alu_result_o = op_a | op_b;
      ALU_XOR:    alu_result_o = op_a ^ op_b;
      ALU_SLT:    alu_result_o = {{(XLEN-1){1'b0}}, less_than};
      ALU_PASS_B: alu_result_o = op_b;
      default:    alu_result_o = op_a + op_b;
    endcase
  end

  // ======================================
  // Branch resolution
  // ======================================

  // Compare register operands, never the immediate
  assign equal           = (op_a == op_b_reg);
  assign branch_taken_o  = branch_i && (branch_ne_i ? !equal : equal);
  assign branch_target_o = pc_i + imm_i;

endmodule

// ==== source/rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch #(
  parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         stall_i,
  input  logic                         branch_taken_i,
  input  logic [rv_core_pkg::XLEN-1:0] branch_target_i,
  output logic [rv_core_pkg::XLEN-1:0] pc_o,
  output logic [rv_core_pkg::XLEN-1:0] pc_plus4_o
);
  import rv_core_pkg::*;

  logic [XLEN-1:0] pc_q;

  // Sequential next address
  assign pc_plus4_o = pc_q + XLEN'(4);
  assign pc_o       = pc_q;

  // Program counter
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pc_q <= RESET_PC;
    end else if (branch_taken_i) begin
      // Redirect wins over a load-use hold
      pc_q <= branch_target_i;
    end else if (!stall_i) begin
      pc_q <= pc_plus4_o;
    end
  end

endmodule

// ==== source/rv_hazard_unit.sv ====
`timescale 1ns/1ps

module rv_hazard_unit (
  input  rv_core_pkg::reg_addr_t id_rs1_i,
  input  rv_core_pkg::reg_addr_t id_rs2_i,
  input  rv_core_pkg::reg_addr_t ex_rs1_i,
  input  rv_core_pkg::reg_addr_t ex_rs2_i,
  input  rv_core_pkg::reg_addr_t ex_rd_i,
  input  logic                   ex_mem_read_i,
  input  rv_core_pkg::reg_addr_t mem_rd_i,
  input  logic                   mem_reg_write_i,
  input  rv_core_pkg::reg_addr_t wb_rd_i,
  input  logic                   wb_reg_write_i,
  input  logic                   branch_taken_i,
  output rv_core_pkg::fwd_sel_e  fwd_a_o,
  output rv_core_pkg::fwd_sel_e  fwd_b_o,
  output logic                   stall_o,
  output logic                   flush_id_o,
  output logic                   flush_ex_o
);
  import rv_core_pkg::*;

  logic load_use;

  // Youngest producer first
  // x0 always reads from the register file
  function automatic fwd_sel_e fwd_for(input reg_addr_t rs);
    if (rs == '0) begin
      return FWD_RF;
    end else if (mem_reg_write_i && (mem_rd_i == rs)) begin
      return FWD_MEM;
    end else if (wb_reg_write_i && (wb_rd_i == rs)) begin
      return FWD_WB;
    end
    return FWD_RF;
  endfunction

  always_comb begin
    fwd_a_o = fwd_for(ex_rs1_i);
    fwd_b_o = fwd_for(ex_rs2_i);
  end

  // Load in execute feeding the instruction in decode
  assign load_use = ex_mem_read_i && (ex_rd_i != '0) &&
                    ((ex_rd_i == id_rs1_i) || (ex_rd_i == id_rs2_i));

  assign stall_o    = load_use;
  // Bubble into execute on a stall or a redirect
  assign flush_ex_o = load_use || branch_taken_i;
  assign flush_id_o = branch_taken_i;

endmodule

// ==== source/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  rv_core_pkg::reg_addr_t       rs1_i,
  input  rv_core_pkg::reg_addr_t       rs2_i,
  input  rv_core_pkg::reg_addr_t       rd_i,
  input  logic                         we_i,
  input  logic [rv_core_pkg::XLEN-1:0] wdata_i,
  output logic [rv_core_pkg::XLEN-1:0] rdata1_o,
  output logic [rv_core_pkg::XLEN-1:0] rdata2_o
);
  import rv_core_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] regs_q [1:31];

  // One read port
  // Same-cycle write data wins over the stored value
  function automatic logic [XLEN-1:0] read_port(input reg_addr_t rs);
    if (rs == '0) begin
      return '0;
    end else if (we_i && (rd_i == rs)) begin
      return wdata_i;
    end
    return regs_q[rs];
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (rd_i != '0)) begin
      regs_q[rd_i] <= wdata_i;
    end
  end

  always_comb begin
    rdata1_o = read_port(rs1_i);
    rdata2_o = read_port(rs2_i);
  end

endmodule

// ==== src.f ====
source/rv_core_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_hazard_unit.sv
source/rv_core.sv
verification/rv_core_tb.sv

// ==== verification/rv_core_patterns.txt ====
# kind test a b, all in hex
# kind 0 program word at a, 1 data word at a, 2 retire of rd a, 3 store to address a
0 1 00000000 00500093  addi x1, x0, 5
0 2 00000004 ffd00113  addi x2, x0, -3
0 2 00000008 002081b3  add  x3, x1, x2
0 2 0000000c 40118233  sub  x4, x3, x1
0 2 00000010 001272b3  and  x5, x4, x1
0 2 00000014 0032e333  or   x6, x5, x3
0 2 00000018 004343b3  xor  x7, x6, x4
0 2 0000001c 0013a433  slt  x8, x7, x1
0 2 00000020 ffb3a493  slti x9, x7, -5
0 2 00000024 0f034513  xori x10, x6, 0xf0
0 2 00000028 10056593  ori  x11, x10, 0x100
0 2 0000002c 0ff5f613  andi x12, x11, 0xff
0 2 00000030 123456b7  lui  x13, 0x12345
0 2 00000034 67868693  addi x13, x13, 0x678
0 3 00000038 10002783  lw   x15, 0x100(x0)
0 3 0000003c 00d78833  add  x16, x15, x13
0 4 00000040 20000893  addi x17, x0, 0x200
0 4 00000044 0108a423  sw   x16, 8(x17)
0 4 00000048 0088a903  lw   x18, 8(x17)
0 5 0000004c 00508663  beq  x1, x5, +12
0 5 00000050 7ff00993  addi x19, x0, 0x7ff   wrong path
0 5 00000054 0018a023  sw   x1, 0(x17)       wrong path
0 5 00000058 00309663  bne  x1, x3, +12
0 5 0000005c 7ff00993  addi x19, x0, 0x7ff   wrong path
0 5 00000060 7ff00a13  addi x20, x0, 0x7ff   wrong path
0 5 00000064 00129463  bne  x5, x1, +8       not taken
0 5 00000068 01500a93  addi x21, x0, 0x15
0 6 0000006c 05508013  addi x0, x1, 0x55
0 6 00000070 00100b33  add  x22, x0, x1
0 6 00000074 0008a623  sw   x0, 12(x17)
1 3 00000100 11110000  word read by the load-use test
2 1 00000001 00000005
2 2 00000002 fffffffd
2 2 00000003 00000002
2 2 00000004 fffffffd
2 2 00000005 00000005
2 2 00000006 00000007
2 2 00000007 fffffffa
2 2 00000008 00000001
2 2 00000009 00000001
2 2 0000000a 000000f7
2 2 0000000b 000001f7
2 2 0000000c 000000f7
2 2 0000000d 12345000
2 2 0000000d 12345678
2 3 0000000f 11110000
2 3 00000010 23455678
2 4 00000011 00000200
3 4 00000208 23455678
2 4 00000012 23455678
2 5 00000015 00000015
2 6 00000016 00000005
3 6 0000020c 00000000

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

  localparam logic [31:0] RESET_PC     = 32'h0000_0000;
  localparam int          RESET_CYCLES = 16;
  localparam int          DRAIN_CYCLES = 12;
  localparam int          IMEM_WORDS   = 1024;
  localparam int          DMEM_WORDS   = 256;
  localparam              PATTERN_FILE = "verification/rv_core_patterns.txt";

  logic        clk_i;
  logic        rst_ni;
  logic [31:0] imem_addr;
  logic [31:0] imem_rdata;
  logic        dmem_re;
  logic        dmem_we;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [31:0] dmem_rdata;
  logic        retire_valid;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;

  // Word-addressed memory models
  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] dmem [DMEM_WORDS];

  // Expected retire and store records in program order
  int          exp_kind [$];
  logic [3:0]  exp_test [$];
  logic [31:0] exp_a [$];
  logic [31:0] exp_b [$];
  int          test_last [16];
  int          test_errors [16] = '{default: 0};

  int          next_exp    = 0;
  int          errors      = 0;
  int          checks      = 0;
  int          prog_words  = 0;
  int          cycles      = 0;
  int          post_cycles = 0;
  int          limit       = 0;
  bit          load_ok     = 1'b0;
  bit          timed_out   = 1'b0;

  rv_core #(
    .RESET_PC(RESET_PC)
  ) u_rv_core (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .imem_addr_o   (imem_addr),
    .imem_rdata_i  (imem_rdata),
    .dmem_re_o     (dmem_re),
    .dmem_we_o     (dmem_we),
    .dmem_addr_o   (dmem_addr),
    .dmem_wdata_o  (dmem_wdata),
    .dmem_rdata_i  (dmem_rdata),
    .retire_valid_o(retire_valid),
    .retire_rd_o   (retire_rd),
    .retire_data_o (retire_data)
  );

  // ======================================
  // Clock and memories
  // ======================================

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Both memories answer in the same cycle
  // Data memory drives read data only under a read strobe
  assign imem_rdata = imem[imem_addr[11:2]];
  assign dmem_rdata = dmem_re ? dmem[dmem_addr[9:2]] : 32'h0;

  always @(posedge clk_i) begin
    if (dmem_we === 1'b1) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  // Unused code space holds opcode 7f, a no-op for this core
  function automatic logic [31:0] fill_instr(input logic [31:0] addr);
    return {addr[31:7] ^ addr[24:0], 7'h7f};
  endfunction

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (rst_ni) begin
      post_cycles <= post_cycles + 1;
    end
  end

  // ======================================
  // Checking
  // ======================================

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp, input logic [3:0] test);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] test %0d %s: got 0x%h, expected 0x%h", test, name, got, exp);
      errors++;
      test_errors[test]++;
    end
  endtask

  // Reset window, plus the first cycle after reset
  task automatic check_quiet();
    check_value("retire_valid_o", {31'b0, retire_valid}, 32'h0, 4'd1);
    check_value("dmem_we_o", {31'b0, dmem_we}, 32'h0, 4'd1);
    check_value("dmem_re_o", {31'b0, dmem_re}, 32'h0, 4'd1);
    if (rst_ni && post_cycles == 0) begin
      check_value("imem_addr_o", imem_addr, RESET_PC, 4'd1);
    end
  endtask

  // Match one retire (kind 2) or store (kind 3) against the next record
  task automatic take_event(input int kind, input logic [31:0] a, input logic [31:0] b);
    logic [3:0] t;
    string      what;
    what = (kind == 2) ? "retire" : "store";
    if (next_exp >= exp_kind.size()) begin
      $display("ERROR: extra %s 0x%h / 0x%h after the last expected record", what, a, b);
      errors++;
      return;
    end
    t = exp_test[next_exp];
    if (exp_kind[next_exp] != kind) begin
      $display("ERROR: test %0d saw a %s where a different event was expected", t, what);
      errors++;
      test_errors[t]++;
    end else if (kind == 2) begin
      check_value("retire_rd_o", a, exp_a[next_exp], t);
      check_value("retire_data_o", b, exp_b[next_exp], t);
    end else begin
      check_value("dmem_addr_o", a, exp_a[next_exp], t);
      check_value("dmem_wdata_o", b, exp_b[next_exp], t);
    end
    if (test_last[t] == next_exp) begin
      $display("test %0d finished with %0d errors", t, test_errors[t]);
    end
    next_exp++;
  endtask

  // Sample in mid cycle, well away from both clock edges
  always @(negedge clk_i) begin
    if (post_cycles <= 1) begin
      check_quiet();
    end else begin
      // Writeback is older than the memory stage
      if (retire_valid === 1'b1) begin
        take_event(2, {27'b0, retire_rd}, retire_data);
      end
      if (dmem_we === 1'b1) begin
        take_event(3, dmem_addr, dmem_wdata);
      end
    end
  end

  // ======================================
  // Pattern loading
  // ======================================

  task automatic load_patterns();
    int          fd;
    int          i;
    int          n;
    int          bad;
    string       line;
    logic [31:0] kind;
    logic [31:0] test;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    bad = 0;
    for (i = 0; i < 16; i++) begin
      test_last[i] = -1;
    end
    for (i = 0; i < IMEM_WORDS; i++) begin
      addr = i * 4;
      imem[addr[11:2]] = fill_instr(addr);
    end
    for (i = 0; i < DMEM_WORDS; i++) begin
      addr = i * 4;
      dmem[addr[9:2]] = addr ^ 32'h5a5a_a5a5;
    end
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("ERROR: cannot open %s", PATTERN_FILE);
      return;
    end
    // Comment lines fail the scan and are skipped
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%h %h %h %h", kind, test, a, b);
      if (n == 4) begin
        if (test > 15) begin
          $display("ERROR: record names test %0d, beyond the last test slot", test);
          bad++;
        end else if (kind == 0) begin
          imem[a[11:2]] = b;
          prog_words++;
        end else if (kind == 1) begin
          dmem[a[9:2]] = b;
        end else if (kind == 2 || kind == 3) begin
          exp_kind.push_back(int'(kind));
          exp_test.push_back(test[3:0]);
          exp_a.push_back(a);
          exp_b.push_back(b);
          test_last[test[3:0]] = exp_kind.size() - 1;
        end else begin
          $display("ERROR: unknown record kind %0h in the pattern file", kind);
          bad++;
        end
      end
    end
    $fclose(fd);
    load_ok = (bad == 0) && (prog_words > 0) && (exp_kind.size() > 0);
  endtask

  // ======================================
  // Main sequence
  // ======================================

  initial begin
    rst_ni = 1'b0;
    load_patterns();
    // Budget of six cycles per program word
    limit = RESET_CYCLES + 6 * prog_words + 50;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    while (next_exp < exp_kind.size() && cycles < limit) begin
      @(posedge clk_i);
    end
    if (next_exp < exp_kind.size()) begin
      timed_out = 1'b1;
      $display("ERROR: timeout after %0d cycles with %0d records still expected",
               cycles, exp_kind.size() - next_exp);
    end else begin
      // Catch late wrong-path events
      repeat (DRAIN_CYCLES) @(posedge clk_i);
    end
    $display("summary: %0d checks, %0d errors, %0d of %0d records matched",
             checks, errors, next_exp, exp_kind.size());
    if (load_ok && !timed_out && errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
